// ==== verilog/regPkg.sv ====
package regPkg;

    // One byte of a register pair as it sits in a bank
    typedef logic [7:0] byte_t;

    // A full register pair value
    typedef logic [15:0] word_t;

    // Pair selector as it appears in commands and on the read selects
    typedef logic [1:0] pairCode_t;

    // Register file address with the alternate set in the top bit
    typedef logic [2:0] regAddr_t;

    // Number of entries in each byte bank, both sets together
    localparam int regCount = 8;

    // Pair codes shared by the main and the alternate set
    localparam pairCode_t pairBC = 2'd0;
    localparam pairCode_t pairDE = 2'd1;
    localparam pairCode_t pairHL = 2'd2;
    localparam pairCode_t pairIX = 2'd3;

    // Operation of the 16-bit address adjuster
    typedef enum logic [1:0] {
        incPass = 2'd0,
        incUp   = 2'd1,
        incDown = 2'd2
    } incMode_t;

    // Turns a pair code into a file address for the current set.
    // IX has no alternate copy, so it always lands in set 0
    function automatic regAddr_t toRegAddr(logic alt, pairCode_t code);
        return {alt && (code != pairIX), code};
    endfunction

endpackage

// ==== verilog/cmdPkg.sv ====
package cmdPkg;

    // Commands understood by the register sequencer.
    // The last code of the 3-bit field is unused and acts as a no-op
    typedef enum logic [2:0] {
        // Both bytes of a pair from the command data
        opWrite     = 3'd0,
        // Low byte only, the high byte keeps its value
        opWriteLow  = 3'd1,
        // High byte only, the low byte keeps its value
        opWriteHigh = 3'd2,
        // Pair plus one, wrapping at the top
        opInc       = 3'd3,
        // Pair minus one, wrapping at zero
        opDec       = 3'd4,
        // Swap BC, DE and HL with their alternates
        opExx       = 3'd5,
        // One block-copy step on HL, DE and BC
        opLdi       = 3'd6
    } cmdOp_t;

    // A command as it arrives with the strobe.
    // The data field is only looked at by the three write opcodes
    typedef struct packed {
        cmdOp_t            op;
        regPkg::pairCode_t pair;
        regPkg::word_t     data;
    } regCmd_t;

    // Sequencer states.
    // Every command passes through stExec once.
    // Only LDI goes on to the DE and BC steps
    typedef enum logic [1:0] {
        stIdle  = 2'd0,
        stExec  = 2'd1,
        stLdiDe = 2'd2,
        stLdiBc = 2'd3
    } seqState_t;

endpackage

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic             Clk,
    input  logic             cen,
    input  logic             weHigh,
    input  logic             weLow,
    input  regPkg::regAddr_t addrA,
    input  regPkg::regAddr_t addrB,
    input  regPkg::regAddr_t addrC,
    input  regPkg::word_t    dataIn,
    output regPkg::word_t    dataA,
    output regPkg::word_t    dataB,
    output regPkg::word_t    dataC
);
    import regPkg::*;

    // Separate banks for the high and low bytes so that each half of a pair
    // can be written on its own
    byte_t highBank [regCount];
    byte_t lowBank  [regCount];

    // Single write port, shared address with read port A.
    // Nothing moves while the core clock enable is low
    always_ff @(posedge Clk) begin
        if (cen) begin
            if (weHigh) begin
                highBank[addrA] <= dataIn[15:8];
            end
            if (weLow) begin
                lowBank[addrA] <= dataIn[7:0];
            end
        end
    end

    // Port A feeds the incrementer, so a read-modify-write of one pair
    // finishes in a single enabled cycle
    assign dataA = {highBank[addrA], lowBank[addrA]};

    // Ports B and C are the outside views.
    // They show the stored value, a write in flight appears after the edge
    assign dataB = {highBank[addrB], lowBank[addrB]};
    assign dataC = {highBank[addrC], lowBank[addrC]};

endmodule

// ==== verilog/pairIncDec.sv ====
`timescale 1ns/1ps

module pairIncDec (
    input  regPkg::incMode_t mode,
    input  regPkg::word_t    operand,
    output regPkg::word_t    result,
    output logic             zero
);
    import regPkg::*;

    // Constant step for both directions
    localparam word_t stepOne = word_t'(1);

    // Plain 16-bit adjust.
    // Overflow wraps around, which is what the pointer registers expect
    always_comb begin
        case (mode)
            incUp: begin
                result = operand + stepOne;
            end
            incDown: begin
                result = operand - stepOne;
            end
            default: begin
                // Pass mode leaves the pair as it is
                result = operand;
            end
        endcase
    end

    // Zero detect on the adjusted value.
    // The sequencer keeps it only on the BC step of LDI
    assign zero = (result == '0);

endmodule

// ==== verilog/regSequencer.sv ====
`timescale 1ns/1ps

module regSequencer (
    input  logic              Clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              cmdStrobe,
    input  cmdPkg::regCmd_t   cmd,
    input  regPkg::word_t     incResult,
    input  logic              incZero,
    output regPkg::regAddr_t  addrA,
    output logic              weHigh,
    output logic              weLow,
    output regPkg::word_t     writeData,
    output regPkg::incMode_t  incMode,
    output logic              altSet,
    output logic              busy,
    output logic              done,
    output logic              bcZero
);
    import regPkg::*;
    import cmdPkg::*;

    seqState_t state;
    seqState_t stateNext;
    regCmd_t   cmdHeld;
    pairCode_t pairSel;
    logic      accept;
    logic      lastStep;
    logic      exxStep;

    // Anything but idle counts as busy.
    // There is no queue, so a strobe in that time is simply lost
    assign busy = (state != stIdle);

    // A command is taken only on an enabled edge while idle
    assign accept = cen && cmdStrobe && !busy;

    // EXX does its whole job in the single execute cycle
    assign exxStep = (state == stExec) && (cmdHeld.op == opExx);

    // Write port control and next state.
    // All outputs come from the held command and the state register
    always_comb begin
        pairSel   = cmdHeld.pair;
        weHigh    = 1'b0;
        weLow     = 1'b0;
        writeData = cmdHeld.data;
        incMode   = incPass;
        stateNext = state;
        lastStep  = 1'b0;

        case (state)
            stIdle: begin
                if (accept) begin
                    stateNext = stExec;
                end
            end
            stExec: begin
                // Everything except LDI returns to idle after this cycle
                stateNext = stIdle;
                lastStep  = 1'b1;
                case (cmdHeld.op)
                    opWrite: begin
                        weHigh = 1'b1;
                        weLow  = 1'b1;
                    end
                    opWriteLow: begin
                        weLow = 1'b1;
                    end
                    opWriteHigh: begin
                        weHigh = 1'b1;
                    end
                    opInc: begin
                        incMode   = incUp;
                        writeData = incResult;
                        weHigh    = 1'b1;
                        weLow     = 1'b1;
                    end
                    opDec: begin
                        incMode   = incDown;
                        writeData = incResult;
                        weHigh    = 1'b1;
                        weLow     = 1'b1;
                    end
                    opLdi: begin
                        // First LDI step moves the source pointer
                        pairSel   = pairHL;
                        incMode   = incUp;
                        writeData = incResult;
                        weHigh    = 1'b1;
                        weLow     = 1'b1;
                        stateNext = stLdiDe;
                        lastStep  = 1'b0;
                    end
                    default: begin
                        // EXX and the spare code leave the file alone
                        weHigh = 1'b0;
                    end
                endcase
            end
            stLdiDe: begin
                // Destination pointer goes up by one
                pairSel   = pairDE;
                incMode   = incUp;
                writeData = incResult;
                weHigh    = 1'b1;
                weLow     = 1'b1;
                stateNext = stLdiBc;
            end
            stLdiBc: begin
                // Byte counter goes down, its zero flag is kept below
                pairSel   = pairBC;
                incMode   = incDown;
                writeData = incResult;
                weHigh    = 1'b1;
                weLow     = 1'b1;
                stateNext = stIdle;
                lastStep  = 1'b1;
            end
            default: begin
                stateNext = stIdle;
            end
        endcase
    end

    // Port A follows the current set, IX excepted
    assign addrA = toRegAddr(altSet, pairSel);

    // Control state.
    // done is a one-cycle pulse after the final write of a command
    always_ff @(posedge Clk) begin
        if (rst) begin
            state  <= stIdle;
            altSet <= 1'b0;
            done   <= 1'b0;
            bcZero <= 1'b0;
        end else if (cen) begin
            state <= stateNext;
            done  <= lastStep;
            if (exxStep) begin
                altSet <= !altSet;
            end
            // Holds its value until the next LDI reaches the BC step
            if (state == stLdiBc) begin
                bcZero <= incZero;
            end
        end
    end

    // Command payload, loaded only when accepted
    always_ff @(posedge Clk) begin
        if (accept) begin
            cmdHeld <= cmd;
        end
    end

endmodule

// ==== verilog/regUnit.sv ====
`timescale 1ns/1ps

module regUnit (
    input  logic               Clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               cmdStrobe,
    input  cmdPkg::regCmd_t    cmd,
    input  regPkg::pairCode_t  selB,
    input  regPkg::pairCode_t  selC,
    output regPkg::word_t      readB,
    output regPkg::word_t      readC,
    output logic               busy,
    output logic               done,
    output logic               bcZero
);
    import regPkg::*;

    regAddr_t addrA;
    regAddr_t addrB;
    regAddr_t addrC;
    logic     weHigh;
    logic     weLow;
    word_t    writeData;
    word_t    dataA;
    word_t    incResult;
    incMode_t incMode;
    logic     incZero;
    logic     altSet;

    // The read selects see the same set as the sequencer.
    // After EXX the outside view flips along with the write side
    assign addrB = toRegAddr(altSet, selB);
    assign addrC = toRegAddr(altSet, selC);

    // Command handling and the write port
    regSequencer regSequencer_i (
        .Clk       (Clk),
        .rst       (rst),
        .cen       (cen),
        .cmdStrobe (cmdStrobe),
        .cmd       (cmd),
        .incResult (incResult),
        .incZero   (incZero),
        .addrA     (addrA),
        .weHigh    (weHigh),
        .weLow     (weLow),
        .writeData (writeData),
        .incMode   (incMode),
        .altSet    (altSet),
        .busy      (busy),
        .done      (done),
        .bcZero    (bcZero)
    );

    // Adjusts whatever pair port A currently points at
    pairIncDec pairIncDec_i (
        .mode    (incMode),
        .operand (dataA),
        .result  (incResult),
        .zero    (incZero)
    );

    // Storage for both register sets
    regFile regFile_i (
        .Clk    (Clk),
        .cen    (cen),
        .weHigh (weHigh),
        .weLow  (weLow),
        .addrA  (addrA),
        .addrB  (addrB),
        .addrC  (addrC),
        .dataIn (writeData),
        .dataA  (dataA),
        .dataB  (readB),
        .dataC  (readC)
    );

endmodule

// ==== bench/regUnitChecker.sv ====
`timescale 1ns/1ps

module regUnitChecker (
    input  logic              Clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              cmdStrobe,
    input  cmdPkg::regCmd_t   cmd,
    input  regPkg::pairCode_t selB,
    input  regPkg::pairCode_t selC,
    input  regPkg::word_t     readB,
    input  regPkg::word_t     readC,
    input  logic              busy,
    input  logic              done,
    input  logic              bcZero,
    output int                errors
);
    import regPkg::*;
    import cmdPkg::*;

    // Both register sets side by side, an entry counts once a full write has set it
    word_t      model [8];
    logic [7:0] known;
    logic       altModel;
    logic       pending;
    logic       expectZero;
    logic       busyExp;
    int         latency;
    int         edgesSince;

    // Set 1 sits four entries above set 0, IX has only the one copy
    function automatic int entryOf(pairCode_t code);
        return int'(code) + ((altModel && code != pairIX) ? 4 : 0);
    endfunction

    task automatic compareRead(input string portName, input pairCode_t sel, input word_t got);
        int idx;
        idx = entryOf(sel);
        if (known[idx] && got !== model[idx]) begin
            $display("ERR %0t: %s shows %h for pair %0d, expected %h",
                     $time, portName, got, sel, model[idx]);
            errors++;
        end
    endtask

    // The whole effect of a command lands in the model on the edge that accepts it.
    // latency counts enabled edges from acceptance to the edge that sees done
    task automatic applyCmd(input regCmd_t c);
        int idx;
        idx = entryOf(c.pair);
        latency = 2;
        case (c.op)
            opWrite: begin
                model[idx] = c.data;
                known[idx] = 1'b1;
            end
            opWriteLow:  model[idx][7:0] = c.data[7:0];
            opWriteHigh: model[idx][15:8] = c.data[15:8];
            opInc:       model[idx] = model[idx] + 16'd1;
            opDec:       model[idx] = model[idx] - 16'd1;
            opExx:       altModel = !altModel;
            opLdi: begin
                // HL and DE step up, the byte count steps down
                model[entryOf(pairHL)] = model[entryOf(pairHL)] + 16'd1;
                model[entryOf(pairDE)] = model[entryOf(pairDE)] + 16'd1;
                model[entryOf(pairBC)] = model[entryOf(pairBC)] - 16'd1;
                expectZero = (model[entryOf(pairBC)] == 16'd0);
                latency = 4;
            end
            default: latency = 2;
        endcase
    endtask

    always @(posedge Clk) begin
        if (rst) begin
            altModel = 1'b0;
            pending  = 1'b0;
            known    = '0;
        end else begin
            // Busy covers every enabled cycle from acceptance up to the one before done
            busyExp = pending && (edgesSince < latency - 1);
            if (busy !== busyExp) begin
                $display("ERR %0t: busy is %b, expected %b", $time, busy, busyExp);
                errors++;
            end
            // Once busy is low every write of the last command has landed
            if (!busyExp) begin
                compareRead("readB", selB, readB);
                compareRead("readC", selC, readC);
            end
            if (cen && pending) begin
                edgesSince++;
                if (done) begin
                    if (edgesSince != latency) begin
                        $display("%0t: done came %0d enabled cycles after the command, not %0d",
                                 $time, edgesSince, latency);
                        errors++;
                    end
                    if (latency == 4 && bcZero !== expectZero) begin
                        $display("ERR %0t: bcZero is %b after LDI, expected %b",
                                 $time, bcZero, expectZero);
                        errors++;
                    end
                    pending = 1'b0;
                end else if (edgesSince >= latency) begin
                    $display("%0t: done never came for the last command", $time);
                    errors++;
                    pending = 1'b0;
                end
            end else if (cen && done) begin
                $display("%0t: done pulsed with no command outstanding", $time);
                errors++;
            end
            // A new command may arrive in the same cycle as done
            if (cen && cmdStrobe && !busyExp) begin
                applyCmd(cmd);
                pending    = 1'b1;
                edgesSince = 0;
            end
        end
    end

endmodule

// ==== bench/regUnitTb.sv ====
`timescale 1ns/1ps

module regUnitTb;
    import regPkg::*;
    import cmdPkg::*;

    // Longest stall a single wait may see, in clock cycles
    localparam int waitLimit = 64;

    logic        Clk;
    logic        rst;
    logic        cen;
    logic        cmdStrobe;
    regCmd_t     cmd;
    pairCode_t   selB;
    pairCode_t   selC;
    word_t       readB;
    word_t       readC;
    logic        busy;
    logic        done;
    logic        bcZero;
    int          errors;
    int          errorsBefore;
    int          testCount;
    int          failedTests;
    int          idx;
    logic        cenRandom;
    logic        junkStrobes;
    logic        hung;

    regUnit regUnit_i (.*);

    regUnitChecker regUnitChecker_i (.*);

    always #4 Clk = !Clk;

    // Free inputs for one cycle, the read selects wander all the time
    task automatic driveBackground();
        cen  = cenRandom ? ($urandom_range(0, 3) != 0) : 1'b1;
        selB = pairCode_t'($urandom_range(0, 3));
        selC = pairCode_t'($urandom_range(0, 3));
    endtask

    function automatic regCmd_t makeCmd(cmdOp_t op, pairCode_t pair, word_t data);
        regCmd_t c;
        c.op   = op;
        c.pair = pair;
        c.data = data;
        return c;
    endfunction

    function automatic regCmd_t randomCmd();
        return makeCmd(cmdOp_t'($urandom_range(0, 6)), pairCode_t'($urandom_range(0, 3)),
                       word_t'($urandom));
    endfunction

    // Strobes a command until it is taken, then waits for done.
    // Returns at the falling edge inside the done cycle
    task automatic runCmd(input regCmd_t c);
        int          tries;
        logic        taken;
        logic [31:0] junk;
        tries = 0;
        taken = 1'b0;
        while (!hung && !taken) begin
            driveBackground();
            cmdStrobe = 1'b1;
            cmd = c;
            taken = cen && !busy;
            @(negedge Clk);
            tries++;
            if (!taken && tries > waitLimit) begin
                $display("Stopped: command %s was never accepted", c.op.name());
                hung = 1'b1;
            end
        end
        tries = 0;
        while (!hung && !done) begin
            driveBackground();
            junk = $urandom;
            // These strobes fall while busy is high and must be dropped
            cmdStrobe = junkStrobes && junk[31];
            cmd = junk[20:0];
            @(negedge Clk);
            tries++;
            if (!done && tries > waitLimit) begin
                $display("Stopped: command %s never signalled done", c.op.name());
                hung = 1'b1;
            end
        end
        cmdStrobe = 1'b0;
    endtask

    // Strobes random commands with cen held low while idle
    task automatic idleJunk(input int cycles);
        logic [31:0] junk;
        repeat (cycles) begin
            junk = $urandom;
            driveBackground();
            cen = 1'b0;
            cmdStrobe = 1'b1;
            cmd = junk[20:0];
            @(negedge Clk);
        end
        cmdStrobe = 1'b0;
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (hung || errors != errorsBefore) begin
            failedTests++;
        end
        $display("test %-10s %0d errors", name, errors - errorsBefore);
        errorsBefore = errors;
    endtask

    initial begin
        Clk = 1'b0;
        rst = 1'b1;
        cen = 1'b0;
        cmdStrobe = 1'b0;
        cmd = '0;
        selB = pairBC;
        selC = pairBC;
        cenRandom = 1'b0;
        junkStrobes = 1'b0;
        hung = 1'b0;
        testCount = 0;
        failedTests = 0;
        errorsBefore = 0;
        void'($urandom(32'hb521_1bf4));
        repeat (2) @(posedge Clk);
        @(negedge Clk);
        rst = 1'b0;

        // All four pairs in both sets, switching sets with EXX
        repeat (2) begin
            for (idx = 0; idx < 4; idx++) begin
                runCmd(makeCmd(opWrite, pairCode_t'(idx), word_t'($urandom)));
            end
            runCmd(makeCmd(opExx, pairBC, '0));
        end
        finishTest("fullWrite");

        repeat (24) begin
            runCmd(makeCmd($urandom_range(0, 1) ? opWriteLow : opWriteHigh,
                           pairCode_t'($urandom_range(0, 3)), word_t'($urandom)));
        end
        finishTest("byteWrite");

        // Both wrap points first, then a random walk
        runCmd(makeCmd(opWrite, pairDE, 16'hFFFF));
        runCmd(makeCmd(opInc, pairDE, '0));
        runCmd(makeCmd(opWrite, pairIX, 16'h0000));
        runCmd(makeCmd(opDec, pairIX, '0));
        repeat (20) begin
            runCmd(makeCmd($urandom_range(0, 1) ? opInc : opDec,
                           pairCode_t'($urandom_range(0, 3)), '0));
        end
        finishTest("incDec");

        cenRandom = 1'b1;
        for (idx = 0; idx < 12; idx++) begin
            // Every third step starts from BC = 1 so the count reaches zero
            if (idx % 3 == 0) begin
                runCmd(makeCmd(opWrite, pairBC, 16'h0001));
            end
            runCmd(makeCmd(opLdi, pairBC, '0));
        end
        finishTest("ldi");

        cenRandom = 1'b0;
        for (idx = 0; idx < 8; idx++) begin
            runCmd(makeCmd(opExx, pairBC, '0));
            runCmd(makeCmd(opWrite, pairCode_t'(idx % 4), word_t'($urandom)));
        end
        runCmd(makeCmd(opExx, pairBC, '0));
        runCmd(makeCmd(opExx, pairBC, '0));
        finishTest("exx");

        cenRandom = 1'b1;
        junkStrobes = 1'b1;
        repeat (40) begin
            runCmd(randomCmd());
            idleJunk($urandom_range(0, 2));
        end
        cenRandom = 1'b0;
        junkStrobes = 1'b0;
        repeat (4) @(negedge Clk);
        finishTest("backPress");

        $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errors);
        if (errors == 0 && !hung) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== regUnit.f ====
verilog/regPkg.sv
verilog/cmdPkg.sv
verilog/regFile.sv
verilog/pairIncDec.sv
verilog/regSequencer.sv
verilog/regUnit.sv
bench/regUnitChecker.sv
bench/regUnitTb.sv

// ==== Makefile ====
TOP := regUnitTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f regUnit.f --top-module $(TOP)

sim:
	verilator --binary --timing -f regUnit.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf obj_dir
